/* dv/sobelTb.sv */
`timescale 1ns/1ps

module sobelTb;

    localparam logic [7:0] unitId = 8'd5;
    localparam int lineWidth = 64;
    localparam int maxRows = 8;
    localparam int wordsPerLine = lineWidth / sobelPkg::wordWidth;

    logic        camClock;
    logic        rstN;
    logic        ciStart;
    logic [7:0]  ciN;
    logic [31:0] ciValueA;
    logic [31:0] ciValueB;
    logic        ciDone;
    logic [31:0] ciResult;
    logic        validCamera;
    logic        hsync;
    logic        vsync;
    logic [7:0]  camData;
    logic        wordValid;
    logic [31:0] wordData;

    logic [7:0]  image [maxRows][lineWidth];
    logic [31:0] expectedWords [$];
    int          wordCount;
    int          modelThreshold;
    int          countBefore;

    sobelTop #(.customId(unitId), .maxLineWidth(lineWidth)) dut (
        .camClock(camClock), .rstN(rstN),
        .ciStart(ciStart), .ciN(ciN), .ciValueA(ciValueA), .ciValueB(ciValueB),
        .ciDone(ciDone), .ciResult(ciResult),
        .validCamera(validCamera), .hsync(hsync), .vsync(vsync), .camData(camData),
        .wordValid(wordValid), .wordData(wordData)
    );

    always #50 camClock = ~camClock;

    task automatic stopRun();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
            stopRun();
        end
    endtask

    function automatic int pixelAt(input int row, input int col);
        return int'(image[row][col]);
    endfunction

    // Sobel rule on the window whose newest pixel is (row, col)
    function automatic logic edgeAt(input int row, input int col, input int thr);
        int gx;
        int gy;
        if (row < 2 || col < 2) begin
            return 1'b0;
        end
        gx = (pixelAt(row - 2, col) + 2 * pixelAt(row - 1, col) + pixelAt(row, col))
           - (pixelAt(row - 2, col - 2) + 2 * pixelAt(row - 1, col - 2)
              + pixelAt(row, col - 2));
        gy = (pixelAt(row, col - 2) + 2 * pixelAt(row, col - 1) + pixelAt(row, col))
           - (pixelAt(row - 2, col - 2) + 2 * pixelAt(row - 2, col - 1)
              + pixelAt(row - 2, col));
        if (gx < 0) gx = -gx;
        if (gy < 0) gy = -gy;
        return (gx + gy) > thr;
    endfunction

    // First pixel of the word lands in bit 31
    function automatic logic [31:0] expectedWord(input int row, input int index,
                                                  input int thr);
        logic [31:0] word;
        word = '0;
        for (int k = 0; k < 32; k++) begin
            word[31 - k] = edgeAt(row, index * 32 + k, thr);
        end
        return word;
    endfunction

    always @(negedge camClock) begin
        if (rstN && wordValid) begin
            assert (expectedWords.size() != 0) else begin
                $display("wordValid pulsed at %0t while no word was expected", $time);
                stopRun();
            end
            checkValue("wordData", expectedWords.pop_front(), wordData);
            wordCount++;
        end
    end

    task automatic runInstruction(input logic [7:0] n, input logic [3:0] op,
                                  input logic [31:0] valueB,
                                  output logic done, output logic [31:0] result);
        @(posedge camClock);
        ciStart <= 1'b1;
        ciN <= n;
        ciValueA <= 32'(op) << sobelPkg::opcodeLsb;
        ciValueB <= valueB;
        @(negedge camClock);
        done = ciDone;
        result = ciResult;
        @(posedge camClock);
        ciStart <= 1'b0;
        ciN <= 8'd0;
        ciValueA <= 32'd0;
        ciValueB <= 32'd0;
    endtask

    task automatic writeRegister(input logic [3:0] op, input logic [31:0] value);
        logic        done;
        logic [31:0] result;
        runInstruction(unitId, op, value, done, result);
        checkValue("ciDone", 32'd1, 32'(done));
        checkValue("ciResult", 32'd0, result);
        if (op == sobelPkg::opWrThreshold) begin
            modelThreshold = int'(value[15:0]);
        end
    endtask

    task automatic readRegister(input logic [3:0] op, input logic [31:0] expected);
        logic        done;
        logic [31:0] result;
        runInstruction(unitId, op, 32'd0, done, result);
        checkValue("ciDone", 32'd1, 32'(done));
        checkValue("ciResult", expected, result);
    endtask

    task automatic fillRandom(input int rows);
        logic [31:0] value;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < lineWidth; c++) begin
                value = $urandom;
                image[r][c] = value[7:0];
            end
        end
    endtask

    // Dark left part, bright from column stepCol on
    task automatic fillStep(input int rows, input int stepCol);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < lineWidth; c++) begin
                image[r][c] = (c < stepCol) ? 8'd0 : 8'd255;
            end
        end
    endtask

    task automatic sendLine(input int row);
        @(posedge camClock);
        hsync <= 1'b1;
        for (int c = 0; c < lineWidth; c++) begin
            @(posedge camClock);
            hsync <= 1'b0;
            validCamera <= 1'b1;
            camData <= image[row][c];
        end
        @(posedge camClock);
        validCamera <= 1'b0;
        camData <= 8'd0;
        // Let the last word leave the pipeline before the next sync
        repeat (8) @(posedge camClock);
    endtask

    task automatic sendFrame(input int rows, input logic expectWords);
        @(posedge camClock);
        vsync <= 1'b1;
        @(posedge camClock);
        vsync <= 1'b0;
        for (int r = 0; r < rows; r++) begin
            if (expectWords) begin
                for (int w = 0; w < wordsPerLine; w++) begin
                    expectedWords.push_back(expectedWord(r, w, modelThreshold));
                end
            end
            sendLine(r);
        end
    endtask

    task automatic waitForDrain(input int limit);
        int cycles;
        cycles = 0;
        while (expectedWords.size() != 0) begin
            @(negedge camClock);
            cycles++;
            if (cycles > limit) begin
                $display("Timed out waiting for %0d packed words", expectedWords.size());
                stopRun();
            end
        end
    endtask

    initial begin
        logic        done;
        logic [31:0] result;
        camClock = 1'b0;
        rstN = 1'b0;
        ciStart = 1'b0;
        ciN = 8'd0;
        ciValueA = 32'd0;
        ciValueB = 32'd0;
        validCamera = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        camData = 8'd0;
        wordCount = 0;
        modelThreshold = 0;
        void'($urandom(32'h881056b9));

        repeat (5) @(posedge camClock);
        rstN <= 1'b1;

        // Reset values
        @(negedge camClock);
        checkValue("ciDone", 32'd0, 32'(ciDone));
        checkValue("wordValid", 32'd0, 32'(wordValid));
        readRegister(sobelPkg::opRdThreshold, 32'd0);
        readRegister(sobelPkg::opRdControl, 32'd0);

        // Register access and decoding
        writeRegister(sobelPkg::opWrThreshold, 32'h0000_1234);
        readRegister(sobelPkg::opRdThreshold, 32'h0000_1234);
        writeRegister(sobelPkg::opWrControl, 32'd1);
        readRegister(sobelPkg::opRdControl, 32'd1);
        runInstruction(8'd6, sobelPkg::opWrThreshold, 32'h0000_0055, done, result);
        checkValue("ciDone", 32'd0, 32'(done));
        checkValue("ciResult", 32'd0, result);
        runInstruction(8'd6, sobelPkg::opRdThreshold, 32'd0, done, result);
        checkValue("ciDone", 32'd0, 32'(done));
        checkValue("ciResult", 32'd0, result);
        // Bit 0 clear so a stray control write would drop the enable
        runInstruction(unitId, 4'b0001, 32'h0000_fffe, done, result);
        checkValue("ciDone", 32'd1, 32'(done));
        checkValue("ciResult", 32'd0, result);
        readRegister(sobelPkg::opRdThreshold, 32'h0000_1234);
        readRegister(sobelPkg::opRdControl, 32'd1);

        // Random frame
        writeRegister(sobelPkg::opWrThreshold, 32'd200);
        fillRandom(6);
        countBefore = wordCount;
        sendFrame(6, 1'b1);
        waitForDrain(200);
        checkValue("word count", 32'(6 * wordsPerLine), 32'(wordCount - countBefore));

        // Vertical step edge
        writeRegister(sobelPkg::opWrThreshold, 32'd100);
        fillStep(4, 20);
        sendFrame(4, 1'b1);
        waitForDrain(200);

        // Output disabled
        writeRegister(sobelPkg::opWrControl, 32'd0);
        fillRandom(4);
        countBefore = wordCount;
        sendFrame(4, 1'b0);
        repeat (20) @(negedge camClock);
        checkValue("word count", 32'd0, 32'(wordCount - countBefore));

        // Busy frame cut short by a new vsync
        writeRegister(sobelPkg::opWrControl, 32'd1);
        writeRegister(sobelPkg::opWrThreshold, 32'd200);
        fillRandom(3);
        sendFrame(3, 1'b1);
        fillRandom(4);
        sendFrame(4, 1'b1);
        waitForDrain(200);

        repeat (10) @(negedge camClock);
        $display("TEST PASS");
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Warnings are still printed, the build only stops on errors
verilator --binary --timing --assert -Wno-fatal \
    --top-module sobelTb -f sim.f -o sobelSim

# Exit status of the binary is the test result
./obj_dir/sobelSim

/* sim.f */
verilog/sobelPkg.sv
verilog/sobelConfigRegs.sv
verilog/sobelLineWindow.sv
verilog/sobelGradient.sv
verilog/edgePacker.sv
verilog/sobelTop.sv
dv/sobelTb.sv

/* verilog/edgePacker.sv */
`timescale 1ns/1ps

module edgePacker (
    input  logic                           camClock,
    input  logic                           rstN,
    input  logic                           edgeValid,
    input  logic                           edgeBit,
    input  logic                           hsync,
    input  logic                           vsync,
    input  logic                           enable,
    output logic                           wordValid,
    output logic [sobelPkg::wordWidth-1:0] wordData
);

    logic [$clog2(sobelPkg::wordWidth)-1:0] bitCount;

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            bitCount <= '0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= 1'b0;
            // Partial word at line end is dropped
            if (hsync || vsync) begin
                bitCount <= '0;
            end else if (edgeValid) begin
                bitCount <= bitCount + 1'b1;
                wordValid <= enable && (bitCount == '1);
            end
        end
    end

    // First pixel ends up in the MSB
    always_ff @(posedge camClock) begin
        if (edgeValid) begin
            wordData <= {wordData[sobelPkg::wordWidth-2:0], edgeBit};
        end
    end

    // One strobe per word, never back to back
    singleStrobe: assert property (
        @(posedge camClock) disable iff (!rstN)
        wordValid |=> !wordValid
    );

endmodule

/* verilog/sobelConfigRegs.sv */
`timescale 1ns/1ps

module sobelConfigRegs #(
    parameter logic [7:0] customId = 8'd0
) (
    input  logic                                camClock,
    input  logic                                rstN,
    input  logic                                ciStart,
    input  logic [7:0]                          ciN,
    input  logic [31:0]                         ciValueA,
    input  logic [31:0]                         ciValueB,
    output logic                                ciDone,
    output logic [31:0]                         ciResult,
    output logic [sobelPkg::thresholdWidth-1:0] threshold,
    output logic                                enable
);

    logic              hit;
    sobelPkg::ciOpcode opcode;

    // Instruction addressed to this unit
    assign hit = ciStart && (ciN == customId);
    assign ciDone = hit;

    assign opcode = sobelPkg::ciOpcode'(
        ciValueA[sobelPkg::opcodeLsb +: $bits(sobelPkg::ciOpcode)]);

    // Read mux where writes and unknown opcodes return zero
    always_comb begin
        ciResult = 32'd0;
        if (hit) begin
            case (opcode)
                sobelPkg::opRdThreshold: begin
                    ciResult = {{(32 - sobelPkg::thresholdWidth){1'b0}}, threshold};
                end
                sobelPkg::opRdControl: begin
                    ciResult = {31'd0, enable};
                end
                default: begin
                    ciResult = 32'd0;
                end
            endcase
        end
    end

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            threshold <= '0;
            enable <= 1'b0;
        end else if (hit) begin
            if (opcode == sobelPkg::opWrThreshold) begin
                threshold <= ciValueB[sobelPkg::thresholdWidth-1:0];
            end
            // Control bit 0 is the enable
            if (opcode == sobelPkg::opWrControl) begin
                enable <= ciValueB[0];
            end
        end
    end

    // Registers only move on an instruction this unit answered
    regsHoldWithoutDone: assert property (
        @(posedge camClock) disable iff (!rstN)
        !$past(ciDone) |-> ($stable(threshold) && $stable(enable))
    );

endmodule

/* verilog/sobelGradient.sv */
`timescale 1ns/1ps

module sobelGradient (
    input  logic                                camClock,
    input  logic                                rstN,
    input  logic                                winValid,
    input  logic                                winComplete,
    input  logic [sobelPkg::pixelWidth-1:0]     winP00,
    input  logic [sobelPkg::pixelWidth-1:0]     winP01,
    input  logic [sobelPkg::pixelWidth-1:0]     winP02,
    input  logic [sobelPkg::pixelWidth-1:0]     winP10,
    input  logic [sobelPkg::pixelWidth-1:0]     winP11,
    input  logic [sobelPkg::pixelWidth-1:0]     winP12,
    input  logic [sobelPkg::pixelWidth-1:0]     winP20,
    input  logic [sobelPkg::pixelWidth-1:0]     winP21,
    input  logic [sobelPkg::pixelWidth-1:0]     winP22,
    input  logic [sobelPkg::thresholdWidth-1:0] threshold,
    output logic                                edgeValid,
    output logic                                edgeBit
);

    logic [sobelPkg::gradWidth-1:0]        posX;
    logic [sobelPkg::gradWidth-1:0]        negX;
    logic [sobelPkg::gradWidth-1:0]        posY;
    logic [sobelPkg::gradWidth-1:0]        negY;
    logic signed [sobelPkg::gradWidth-1:0] gradX;
    logic signed [sobelPkg::gradWidth-1:0] gradY;
    logic                                  stageValid;
    logic                                  stageComplete;
    logic [sobelPkg::magWidth-1:0]         absX;
    logic [sobelPkg::magWidth-1:0]         absY;
    logic [sobelPkg::magWidth-1:0]         magnitude;

    function automatic logic [sobelPkg::gradWidth-1:0] widen(
        input logic [sobelPkg::pixelWidth-1:0] p
    );
        return {{(sobelPkg::gradWidth - sobelPkg::pixelWidth){1'b0}}, p};
    endfunction

    // 1-2-1 weighted sum of three taps
    function automatic logic [sobelPkg::gradWidth-1:0] tapSum(
        input logic [sobelPkg::pixelWidth-1:0] a,
        input logic [sobelPkg::pixelWidth-1:0] b,
        input logic [sobelPkg::pixelWidth-1:0] c
    );
        return widen(a) + (widen(b) << sobelPkg::centerShift) + widen(c);
    endfunction

    assign posX = tapSum(winP02, winP12, winP22);
    assign negX = tapSum(winP00, winP10, winP20);
    assign posY = tapSum(winP20, winP21, winP22);
    assign negY = tapSum(winP00, winP01, winP02);

    // Stage one, signed gradients (fit in 12 bits, max 1020)
    always_ff @(posedge camClock) begin
        gradX <= posX - negX;
        gradY <= posY - negY;
    end

    assign absX = gradX[sobelPkg::gradWidth-1] ? -gradX : gradX;
    assign absY = gradY[sobelPkg::gradWidth-1] ? -gradY : gradY;
    assign magnitude = absX + absY;

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            stageValid <= 1'b0;
            stageComplete <= 1'b0;
            edgeValid <= 1'b0;
            edgeBit <= 1'b0;
        end else begin
            stageValid <= winValid;
            stageComplete <= winComplete;
            edgeValid <= stageValid;
            // Stage two, strict compare against threshold
            edgeBit <= stageValid && stageComplete &&
                ({{(sobelPkg::thresholdWidth - sobelPkg::magWidth){1'b0}}, magnitude}
                 > threshold);
        end
    end

endmodule

/* verilog/sobelLineWindow.sv */
`timescale 1ns/1ps

module sobelLineWindow #(
    parameter int maxLineWidth = 512
) (
    input  logic                            camClock,
    input  logic                            rstN,
    input  logic                            validCamera,
    input  logic                            hsync,
    input  logic                            vsync,
    input  logic [sobelPkg::pixelWidth-1:0] camData,
    output logic                            winValid,
    output logic                            winComplete,
    output logic [sobelPkg::pixelWidth-1:0] winP00,
    output logic [sobelPkg::pixelWidth-1:0] winP01,
    output logic [sobelPkg::pixelWidth-1:0] winP02,
    output logic [sobelPkg::pixelWidth-1:0] winP10,
    output logic [sobelPkg::pixelWidth-1:0] winP11,
    output logic [sobelPkg::pixelWidth-1:0] winP12,
    output logic [sobelPkg::pixelWidth-1:0] winP20,
    output logic [sobelPkg::pixelWidth-1:0] winP21,
    output logic [sobelPkg::pixelWidth-1:0] winP22
);

    localparam int addrWidth = $clog2(maxLineWidth);

    // One spare bit so a full line does not wrap back to zero
    logic [addrWidth:0]              colCount;
    logic [addrWidth-1:0]            colAddr;
    logic [1:0]                      rowCount;
    logic [sobelPkg::pixelWidth-1:0] lineMem0 [maxLineWidth];
    logic [sobelPkg::pixelWidth-1:0] lineMem1 [maxLineWidth];
    logic [sobelPkg::pixelWidth-1:0] oldPixel;
    logic [sobelPkg::pixelWidth-1:0] prevPixel;

    assign colAddr = colCount[addrWidth-1:0];

    // lineMem0 holds two lines back, lineMem1 the line before
    assign oldPixel = lineMem0[colAddr];
    assign prevPixel = lineMem1[colAddr];

    // Row saturates at 2, which is all the window needs to know
    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            colCount <= '0;
            rowCount <= '0;
        end else if (vsync) begin
            colCount <= '0;
            rowCount <= '0;
        end else if (hsync) begin
            colCount <= '0;
            // Only count a row once it actually carried pixels
            if (colCount != '0 && rowCount != 2'd2) begin
                rowCount <= rowCount + 2'd1;
            end
        end else if (validCamera) begin
            colCount <= colCount + 1'b1;
        end
    end

    always_ff @(posedge camClock or negedge rstN) begin
        if (!rstN) begin
            winValid <= 1'b0;
            winComplete <= 1'b0;
        end else begin
            winValid <= validCamera;
            if (validCamera) begin
                // Upper bits nonzero means column >= 2
                winComplete <= (rowCount == 2'd2) && (|colCount[addrWidth:1]);
            end
        end
    end

    // Line memories and window shift, new column enters at column 2
    always_ff @(posedge camClock) begin
        if (validCamera) begin
            lineMem0[colAddr] <= prevPixel;
            lineMem1[colAddr] <= camData;

            winP00 <= winP01;
            winP01 <= winP02;
            winP02 <= oldPixel;

            winP10 <= winP11;
            winP11 <= winP12;
            winP12 <= prevPixel;

            winP20 <= winP21;
            winP21 <= winP22;
            winP22 <= camData;
        end
    end

    // Camera never mixes sync pulses with pixels
    noPixelOnSync: assert property (
        @(posedge camClock) disable iff (!rstN)
        validCamera |-> !(hsync || vsync)
    );

endmodule

/* verilog/sobelPkg.sv */
package sobelPkg;

    // Stream and datapath widths
    localparam int pixelWidth = 8;
    localparam int gradWidth = 12;
    localparam int magWidth = 12;
    localparam int thresholdWidth = 16;
    localparam int wordWidth = 32;

    // Center tap of the 1-2-1 kernel, applied as a left shift
    localparam int centerShift = 1;

    // Lowest bit of the opcode field in ciValueA
    localparam int opcodeLsb = 9;

    // Custom instruction opcodes
    // bit 0 set means write, bit 1 selects control instead of threshold
    typedef enum logic [3:0] {
        opRdThreshold = 4'b1000,
        opWrThreshold = 4'b1001,
        opRdControl   = 4'b1010,
        opWrControl   = 4'b1011
    } ciOpcode;

endpackage

/* verilog/sobelTop.sv */
`timescale 1ns/1ps

module sobelTop #(
    parameter logic [7:0] customId = 8'd0,
    parameter int maxLineWidth = 512
) (
    input  logic                           camClock,
    input  logic                           rstN,
    input  logic                           ciStart,
    input  logic [7:0]                     ciN,
    input  logic [31:0]                    ciValueA,
    input  logic [31:0]                    ciValueB,
    output logic                           ciDone,
    output logic [31:0]                    ciResult,
    input  logic                           validCamera,
    input  logic                           hsync,
    input  logic                           vsync,
    input  logic [sobelPkg::pixelWidth-1:0] camData,
    output logic                           wordValid,
    output logic [sobelPkg::wordWidth-1:0] wordData
);

    logic [sobelPkg::thresholdWidth-1:0] threshold;
    logic                                enable;
    logic                                winValid;
    logic                                winComplete;
    logic [sobelPkg::pixelWidth-1:0]     winP00, winP01, winP02;
    logic [sobelPkg::pixelWidth-1:0]     winP10, winP11, winP12;
    logic [sobelPkg::pixelWidth-1:0]     winP20, winP21, winP22;
    logic                                edgeValid;
    logic                                edgeBit;

    sobelConfigRegs #(.customId(customId)) configRegs (
        .camClock(camClock), .rstN(rstN),
        .ciStart(ciStart), .ciN(ciN),
        .ciValueA(ciValueA), .ciValueB(ciValueB),
        .ciDone(ciDone), .ciResult(ciResult),
        .threshold(threshold), .enable(enable)
    );

    sobelLineWindow #(.maxLineWidth(maxLineWidth)) lineWindow (
        .camClock(camClock), .rstN(rstN),
        .validCamera(validCamera), .hsync(hsync), .vsync(vsync), .camData(camData),
        .winValid(winValid), .winComplete(winComplete),
        .winP00(winP00), .winP01(winP01), .winP02(winP02),
        .winP10(winP10), .winP11(winP11), .winP12(winP12),
        .winP20(winP20), .winP21(winP21), .winP22(winP22)
    );

    sobelGradient gradient (
        .camClock(camClock), .rstN(rstN),
        .winValid(winValid), .winComplete(winComplete),
        .winP00(winP00), .winP01(winP01), .winP02(winP02),
        .winP10(winP10), .winP11(winP11), .winP12(winP12),
        .winP20(winP20), .winP21(winP21), .winP22(winP22),
        .threshold(threshold),
        .edgeValid(edgeValid), .edgeBit(edgeBit)
    );

    edgePacker packer (
        .camClock(camClock), .rstN(rstN),
        .edgeValid(edgeValid), .edgeBit(edgeBit),
        .hsync(hsync), .vsync(vsync), .enable(enable),
        .wordValid(wordValid), .wordData(wordData)
    );

endmodule
